//--- logic/zc_msg_pkg.sv
/*
  Message formats used between the host FIFOs and the core stages.
  A message is one header word followed by len payload words.
  A reply is always a header word with len 1, then one value word.
  Lengths above the FIFO depth are legal; the core streams them.
*/
package zc_msg_pkg;

  // Every message word, commands and replies alike
  localparam int ZC_WORD_W = 32;

  // Command codes in header bits 31:24
  localparam logic [7:0] ZC_CMD_STATUS = 8'h01;
  localparam logic [7:0] ZC_CMD_SUM    = 8'h02;
  localparam logic [7:0] ZC_CMD_XROT   = 8'h03;

  // Reply status codes in header bits 23:16
  localparam logic [7:0] ZC_ST_OK      = 8'h00;
  localparam logic [7:0] ZC_ST_BAD_CMD = 8'h01;

  // Core version answered by STATUS
  localparam logic [ZC_WORD_W-1:0] ZC_VERSION = 32'h5a43_0100;

  // Buffer sizes
  localparam int ZC_CMD_FIFO_DEPTH = 16;
  localparam int ZC_RES_FIFO_DEPTH = 4;

  typedef struct packed {
    logic [7:0]  cmd;
    logic [7:0]  status;
    logic [15:0] len;
  } zc_hdr_t;

  // One payload word as seen by execute
  typedef struct packed {
    logic [7:0]           cmd;
    logic                 first;
    logic                 last;
    logic                 has_data;
    logic [ZC_WORD_W-1:0] data;
  } zc_item_t;

  typedef struct packed {
    logic [7:0]           cmd;
    logic [7:0]           status;
    logic [ZC_WORD_W-1:0] value;
  } zc_result_t;

endpackage

//--- logic/zc_host_pkg.sv
/*
  Host view of the accelerator over APB.
  Only 32-bit accesses at word offsets are decoded.
  Unmapped offsets and wrong-direction accesses answer pslverr.
*/
package zc_host_pkg;

  localparam int ZC_ADDR_W     = 8;
  localparam int ZC_APB_DATA_W = 32;

  // Register offsets
  localparam logic [ZC_ADDR_W-1:0] ZC_REG_CMD  = 8'h00;
  localparam logic [ZC_ADDR_W-1:0] ZC_REG_RPL  = 8'h04;
  localparam logic [ZC_ADDR_W-1:0] ZC_REG_STAT = 8'h08;

  // STAT register, upper bits read as zero
  typedef struct packed {
    logic [21:0] rsvd;
    logic        bus_err;
    logic        cmd_full;
    logic [7:0]  rpl_count;
  } zc_stat_t;

  // Signals driven by the APB master
  typedef struct packed {
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [ZC_ADDR_W-1:0]     paddr;
    logic [ZC_APB_DATA_W-1:0] pwdata;
  } zc_apb_req_t;

endpackage

//--- logic/zc_fifo.sv
/*
  Synchronous FIFO with a registered full flag and output valid.
  Input ready is the inverse of full and never waits on the reader.
  A pushed entry shows at the output one cycle later.
  Any DEPTH of at least 2 works; pointers wrap explicitly.
*/
`timescale 1ns/1ps

module zc_fifo #(
  parameter type T     = logic [31:0],
  parameter int  DEPTH = 16
) (
  input  logic clk_100,
  input  logic rst_main_n,
  input  logic i_valid,
  input  T     i_data,
  input  logic i_ready_out,
  output logic o_ready_in,
  output logic o_valid,
  output T     o_data,
  output logic o_full
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  T                 mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic [CNT_W-1:0] count_next;
  logic             full_q;
  logic             valid_q;
  logic             push;
  logic             pop;

  assign push = i_valid & ~full_q;
  assign pop  = valid_q & i_ready_out;

  assign count_next = count_q + CNT_W'(push) - CNT_W'(pop);

  // Storage, no reset on the entries
  always_ff @(posedge clk_100) begin
    if (push) begin
      mem[wr_ptr_q] <= i_data;
    end
  end

  always_ff @(posedge clk_100) begin
    if (!rst_main_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      full_q   <= 1'b0;
      valid_q  <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_next;
      // Flags follow the next count so they stay registered
      full_q  <= (count_next == CNT_W'(DEPTH));
      valid_q <= (count_next != '0);
    end
  end

  assign o_ready_in = ~full_q;
  assign o_full     = full_q;
  assign o_valid    = valid_q;
  assign o_data     = mem[rd_ptr_q];

endmodule

//--- logic/zc_apb_regs.sv
/*
  APB slave for the command and reply registers, zero wait states.
  The register map is decoded in the setup cycle; read data, pready,
  pslverr and the FIFO strobes are registered into the access cycle.
  Assumes a compliant master that holds paddr and pwdata through access.
  The sticky bus error clears only at reset.
*/
`timescale 1ns/1ps

module zc_apb_regs
  import zc_host_pkg::*;
(
  input  logic                     clk_100,
  input  logic                     rst_main_n,
  input  zc_apb_req_t              i_apb,
  input  logic                     i_cmd_full,
  input  logic [ZC_APB_DATA_W-1:0] i_rpl_word,
  input  logic [7:0]               i_rpl_count,
  output logic [ZC_APB_DATA_W-1:0] o_prdata,
  output logic                     o_pready,
  output logic                     o_pslverr,
  output logic                     o_cmd_push,
  output logic [ZC_APB_DATA_W-1:0] o_cmd_word,
  output logic                     o_rpl_pop
);

  logic                     setup;
  logic                     push_ok;
  logic                     pop_ok;
  logic                     bad;
  logic [ZC_APB_DATA_W-1:0] rdata_next;
  logic                     err_sticky_q;
  zc_stat_t                 stat;

  always_comb begin
    stat           = '0;
    stat.rpl_count = i_rpl_count;
    stat.cmd_full  = i_cmd_full;
    stat.bus_err   = err_sticky_q;
  end

  // Setup phase of a transfer
  assign setup = i_apb.psel & ~i_apb.penable;

  // --------------------------------------------------------------------------
  // Register map decode
  // --------------------------------------------------------------------------
  always_comb begin
    push_ok    = 1'b0;
    pop_ok     = 1'b0;
    bad        = 1'b0;
    rdata_next = '0;
    case (i_apb.paddr)
      ZC_REG_CMD: begin
        // Only this slave pushes, so full cannot clear into a lost word
        if (i_apb.pwrite) begin
          push_ok = ~i_cmd_full;
          bad     = i_cmd_full;
        end else begin
          bad = 1'b1;
        end
      end
      ZC_REG_RPL: begin
        if (!i_apb.pwrite && i_rpl_count != 8'd0) begin
          pop_ok     = 1'b1;
          rdata_next = i_rpl_word;
        end else begin
          bad = 1'b1;
        end
      end
      ZC_REG_STAT: begin
        if (!i_apb.pwrite) begin
          rdata_next = stat;
        end else begin
          bad = 1'b1;
        end
      end
      default: bad = 1'b1;
    endcase
  end

  // --------------------------------------------------------------------------
  // Access cycle response
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_100) begin
    if (!rst_main_n) begin
      o_pready     <= 1'b0;
      o_pslverr    <= 1'b0;
      o_cmd_push   <= 1'b0;
      o_rpl_pop    <= 1'b0;
      err_sticky_q <= 1'b0;
    end else begin
      o_pready   <= setup;
      o_pslverr  <= setup & bad;
      o_cmd_push <= setup & push_ok;
      o_rpl_pop  <= setup & pop_ok;
      if (setup && bad) begin
        err_sticky_q <= 1'b1;
      end
    end
  end

  // Read data, zero for writes and errors
  always_ff @(posedge clk_100) begin
    if (setup) begin
      o_prdata <= rdata_next;
    end
  end

  // pwdata is still held in the access cycle when the push lands
  assign o_cmd_word = i_apb.pwdata;

endmodule

//--- logic/zc_decode.sv
/*
  Header parser between the command FIFO and execute.
  A header takes one cycle; payload words then pass through as items,
  one per cycle, tagged with command and first/last flags.
  A zero-length message yields one marker item with has_data clear.
*/
`timescale 1ns/1ps

module zc_decode
  import zc_msg_pkg::*;
(
  input  logic                 clk_100,
  input  logic                 rst_main_n,
  input  logic                 i_word_valid,
  input  logic [ZC_WORD_W-1:0] i_word,
  input  logic                 i_item_ready,
  output logic                 o_word_ready,
  output logic                 o_item_valid,
  output zc_item_t             o_item
);

  typedef enum logic {
    ST_HDR,
    ST_PAY
  } state_t;

  state_t      state_q;
  zc_hdr_t     hdr;
  logic [7:0]  cmd_q;
  logic [15:0] rem_q;
  logic        first_q;
  logic        marker;
  logic        item_fire;

  assign hdr = zc_hdr_t'(i_word);

  // Payload state with nothing left means an empty message
  assign marker = (state_q == ST_PAY) && (rem_q == 16'd0);

  always_comb begin
    if (state_q == ST_HDR) begin
      // Headers are always taken
      o_word_ready = 1'b1;
      o_item_valid = 1'b0;
    end else if (marker) begin
      o_word_ready = 1'b0;
      o_item_valid = 1'b1;
    end else begin
      o_word_ready = i_item_ready;
      o_item_valid = i_word_valid;
    end
  end

  always_comb begin
    o_item.cmd      = cmd_q;
    o_item.first    = first_q;
    o_item.last     = (rem_q <= 16'd1);
    o_item.has_data = ~marker;
    o_item.data     = marker ? '0 : i_word;
  end

  assign item_fire = o_item_valid & i_item_ready;

  always_ff @(posedge clk_100) begin
    if (!rst_main_n) begin
      state_q <= ST_HDR;
      cmd_q   <= '0;
      rem_q   <= '0;
      first_q <= 1'b0;
    end else begin
      case (state_q)
        ST_HDR: begin
          if (i_word_valid) begin
            cmd_q   <= hdr.cmd;
            rem_q   <= hdr.len;
            first_q <= 1'b1;
            state_q <= ST_PAY;
          end
        end
        ST_PAY: begin
          if (item_fire) begin
            first_q <= 1'b0;
            if (!marker) begin
              rem_q <= rem_q - 1'b1;
            end
            // Last item closes the message
            if (rem_q <= 16'd1) begin
              state_q <= ST_HDR;
            end
          end
        end
        default: state_q <= ST_HDR;
      endcase
    end
  end

endmodule

//--- logic/zc_execute.sv
/*
  Per-message accumulator for SUM and XROT.
  The result is registered one cycle after the last item; the next
  message may start in that same cycle.
  Items stall only while a finished result waits for the FIFO.
*/
`timescale 1ns/1ps

module zc_execute
  import zc_msg_pkg::*;
(
  input  logic                 clk_100,
  input  logic                 rst_main_n,
  input  logic                 i_item_valid,
  input  zc_item_t             i_item,
  input  logic                 i_res_ready,
  output logic                 o_item_ready,
  output logic                 o_res_valid,
  output zc_result_t           o_res
);

  logic [ZC_WORD_W-1:0] acc_q;
  logic [ZC_WORD_W-1:0] base;
  logic [ZC_WORD_W-1:0] acc_next;
  logic                 item_fire;
  logic                 res_valid_q;
  zc_result_t           res_q;
  zc_result_t           res_next;

  assign o_item_ready = ~res_valid_q | i_res_ready;
  assign item_fire    = i_item_valid & o_item_ready;

  // Fresh start on the first item of every message
  assign base = i_item.first ? '0 : acc_q;

  always_comb begin
    acc_next = base;
    if (i_item.has_data) begin
      case (i_item.cmd)
        ZC_CMD_SUM:  acc_next = base + i_item.data;
        // Rotate left by one, then fold in the word
        ZC_CMD_XROT: acc_next = {base[ZC_WORD_W-2:0], base[ZC_WORD_W-1]} ^ i_item.data;
        default:     acc_next = base;
      endcase
    end
  end

  always_comb begin
    res_next.cmd    = i_item.cmd;
    res_next.status = ZC_ST_OK;
    case (i_item.cmd)
      ZC_CMD_STATUS: res_next.value = ZC_VERSION;
      ZC_CMD_SUM,
      ZC_CMD_XROT:   res_next.value = acc_next;
      default: begin
        res_next.status = ZC_ST_BAD_CMD;
        res_next.value  = '0;
      end
    endcase
  end

  always_ff @(posedge clk_100) begin
    if (!rst_main_n) begin
      res_valid_q <= 1'b0;
    end else if (item_fire && i_item.last) begin
      res_valid_q <= 1'b1;
    end else if (i_res_ready) begin
      res_valid_q <= 1'b0;
    end
  end

  // Payload registers
  always_ff @(posedge clk_100) begin
    if (item_fire) begin
      acc_q <= acc_next;
      if (i_item.last) begin
        res_q <= res_next;
      end
    end
  end

  assign o_res_valid = res_valid_q;
  assign o_res       = res_q;

endmodule

//--- logic/zc_result.sv
/*
  Reply formatter holding one result at a time.
  Offers the header word first, then the value word.
  A new result loads only after both words are popped.
*/
`timescale 1ns/1ps

module zc_result
  import zc_msg_pkg::*;
(
  input  logic                 clk_100,
  input  logic                 rst_main_n,
  input  logic                 i_res_valid,
  input  zc_result_t           i_res,
  input  logic                 i_rpl_pop,
  output logic                 o_res_ready,
  output logic [ZC_WORD_W-1:0] o_rpl_word,
  output logic [7:0]           o_rpl_count
);

  zc_result_t res_q;
  zc_hdr_t    hdr;
  logic [1:0] cnt_q;

  // Words still to hand out, 2 means header next
  assign o_res_ready = (cnt_q == 2'd0);

  always_ff @(posedge clk_100) begin
    if (!rst_main_n) begin
      cnt_q <= 2'd0;
    end else if (i_res_valid && o_res_ready) begin
      cnt_q <= 2'd2;
    end else if (i_rpl_pop && cnt_q != 2'd0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_100) begin
    if (i_res_valid && o_res_ready) begin
      res_q <= i_res;
    end
  end

  // Reply header always announces one value word
  always_comb begin
    hdr.cmd    = res_q.cmd;
    hdr.status = res_q.status;
    hdr.len    = 16'd1;
  end

  assign o_rpl_word  = (cnt_q == 2'd2) ? hdr : res_q.value;
  assign o_rpl_count = {6'd0, cnt_q};

endmodule

//--- logic/zc_accel_top.sv
/*
  Message accelerator top level, single clock domain.
  APB slave, command FIFO, decode, execute, result FIFO, reply formatter.
  End-to-end latency varies; poll STAT for a nonzero reply count.
*/
`timescale 1ns/1ps

module zc_accel_top
  import zc_msg_pkg::*;
  import zc_host_pkg::*;
(
  input  logic                     clk_100,
  input  logic                     rst_main_n,
  input  zc_apb_req_t              i_apb,
  output logic [ZC_APB_DATA_W-1:0] o_prdata,
  output logic                     o_pready,
  output logic                     o_pslverr
);

  // Host side
  logic                 cmd_push;
  logic [ZC_WORD_W-1:0] cmd_word;
  logic                 cmd_full;
  logic [ZC_WORD_W-1:0] rpl_word;
  logic [7:0]           rpl_count;
  logic                 rpl_pop;

  // Core stages
  logic                 word_valid;
  logic [ZC_WORD_W-1:0] word;
  logic                 word_ready;
  logic                 item_valid;
  zc_item_t             item;
  logic                 item_ready;
  logic                 exe_valid;
  zc_result_t           exe_res;
  logic                 exe_ready;
  logic                 fifo_res_valid;
  zc_result_t           fifo_res;
  logic                 fifo_res_ready;

  zc_apb_regs u_zc_apb_regs (
    .clk_100     (clk_100),
    .rst_main_n  (rst_main_n),
    .i_apb       (i_apb),
    .i_cmd_full  (cmd_full),
    .i_rpl_word  (rpl_word),
    .i_rpl_count (rpl_count),
    .o_prdata    (o_prdata),
    .o_pready    (o_pready),
    .o_pslverr   (o_pslverr),
    .o_cmd_push  (cmd_push),
    .o_cmd_word  (cmd_word),
    .o_rpl_pop   (rpl_pop)
  );

  // Push is already qualified by full inside the slave
  zc_fifo #(
    .T     (logic [ZC_WORD_W-1:0]),
    .DEPTH (ZC_CMD_FIFO_DEPTH)
  ) u_cmd_fifo (
    .clk_100     (clk_100),
    .rst_main_n  (rst_main_n),
    .i_valid     (cmd_push),
    .i_data      (cmd_word),
    .i_ready_out (word_ready),
    .o_ready_in  (),
    .o_valid     (word_valid),
    .o_data      (word),
    .o_full      (cmd_full)
  );

  zc_decode u_zc_decode (
    .clk_100      (clk_100),
    .rst_main_n   (rst_main_n),
    .i_word_valid (word_valid),
    .i_word       (word),
    .i_item_ready (item_ready),
    .o_word_ready (word_ready),
    .o_item_valid (item_valid),
    .o_item       (item)
  );

  zc_execute u_zc_execute (
    .clk_100      (clk_100),
    .rst_main_n   (rst_main_n),
    .i_item_valid (item_valid),
    .i_item       (item),
    .i_res_ready  (exe_ready),
    .o_item_ready (item_ready),
    .o_res_valid  (exe_valid),
    .o_res        (exe_res)
  );

  zc_fifo #(
    .T     (zc_result_t),
    .DEPTH (ZC_RES_FIFO_DEPTH)
  ) u_res_fifo (
    .clk_100     (clk_100),
    .rst_main_n  (rst_main_n),
    .i_valid     (exe_valid),
    .i_data      (exe_res),
    .i_ready_out (fifo_res_ready),
    .o_ready_in  (exe_ready),
    .o_valid     (fifo_res_valid),
    .o_data      (fifo_res),
    .o_full      ()
  );

  zc_result u_zc_result (
    .clk_100     (clk_100),
    .rst_main_n  (rst_main_n),
    .i_res_valid (fifo_res_valid),
    .i_res       (fifo_res),
    .i_rpl_pop   (rpl_pop),
    .o_res_ready (fifo_res_ready),
    .o_rpl_word  (rpl_word),
    .o_rpl_count (rpl_count)
  );

endmodule

//--- tests/zc_tb_clock.sv
/*
  Testbench clock and reset source.
  20 ns clock period; reset is held low for RST_CYCLES rising edges
  and is released 2 ns after the last one.
*/
`timescale 1ns/1ps

module zc_tb_clock #(
  parameter int RST_CYCLES = 10
) (
  output logic o_clk_100,
  output logic o_rst_main_n
);

  localparam time HALF_PERIOD = 10ns;

  initial begin
    o_clk_100 = 1'b0;
    forever #(HALF_PERIOD) o_clk_100 = ~o_clk_100;
  end

  // Release away from the edge, like all other testbench drives
  initial begin
    o_rst_main_n = 1'b0;
    repeat (RST_CYCLES) @(posedge o_clk_100);
    #2;
    o_rst_main_n = 1'b1;
  end

endmodule

//--- tests/zc_tb.sv
/*
  Testbench for the message accelerator, driven over its APB port.
  Replies are compared with a reference model of the command rules.
  Only one message is in flight outside the overflow phase.
  Inputs change 2 ns after the rising edge; APB outputs are sampled at
  the falling edge of the access cycle.
*/
`timescale 1ns/1ps

module zc_tb
  import zc_msg_pkg::*;
  import zc_host_pkg::*;
();

  localparam int         MAX_LEN     = 12;
  localparam int         NUM_RAND    = 40;
  localparam int         BP_MSGS     = 24;
  localparam int         POLL_MAX    = 200;
  localparam int         NUM_MSGS    = 1 + NUM_RAND + 2 + BP_MSGS + 1;
  localparam int         WD_CYCLES   = NUM_MSGS * (MAX_LEN + 30) * 10;
  localparam logic [7:0] CMD_UNKNOWN = 8'h7e;

  typedef logic [31:0] pay_t [MAX_LEN];

  logic        clk_100;
  logic        rst_main_n;
  zc_apb_req_t apb;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  integer      seed = 32'h924c_610a;
  logic        wr_err;
  int          n_exp = 0;
  int          n_cmp = 0;
  logic [31:0] got_q [$];
  logic [31:0] exp_q [$];

  // Messages of the overflow phase kept for the drain
  logic [7:0]  bp_cmd [BP_MSGS];
  int          bp_len [BP_MSGS];
  pay_t        bp_pay [BP_MSGS];

  zc_tb_clock u_zc_tb_clock (
    .o_clk_100    (clk_100),
    .o_rst_main_n (rst_main_n)
  );

  zc_accel_top u_zc_accel_top (
    .clk_100    (clk_100),
    .rst_main_n (rst_main_n),
    .i_apb      (apb),
    .o_prdata   (prdata),
    .o_pready   (pready),
    .o_pslverr  (pslverr)
  );

  // --------------------------------------------------------------------------
  // Failure reporting and value compare
  // --------------------------------------------------------------------------
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
      fail_run("value check failed");
    end
  endtask

  // --------------------------------------------------------------------------
  // APB master
  // --------------------------------------------------------------------------
  task automatic apb_transfer(input logic [7:0] addr, input logic wr,
                              input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
    // Setup cycle
    @(posedge clk_100);
    #2;
    apb         = '0;
    apb.psel    = 1'b1;
    apb.pwrite  = wr;
    apb.paddr   = addr;
    apb.pwdata  = wdata;
    // Access cycle holds address and data
    @(posedge clk_100);
    #2;
    apb.penable = 1'b1;
    @(negedge clk_100);
    if (pready !== 1'b1) begin
      fail_run("pready was low in an APB access cycle");
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk_100);
    #2;
    apb = '0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    apb_transfer(addr, 1'b1, data, unused, wr_err);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                          output logic err);
    apb_transfer(addr, 1'b0, 32'h0, data, err);
  endtask

  task automatic cmd_write(input logic [31:0] word);
    apb_write(ZC_REG_CMD, word);
    if (wr_err) begin
      fail_run("a CMD write got pslverr while the FIFO had room");
    end
  endtask

  // --------------------------------------------------------------------------
  // Message building and reference model
  // --------------------------------------------------------------------------
  // Word w of a message where w = 0 is the header
  function automatic logic [31:0] msg_word(input logic [7:0] cmd, input int len,
                                           input pay_t p, input int w);
    zc_hdr_t h;
    h.cmd    = cmd;
    h.status = ZC_ST_OK;
    h.len    = 16'(len);
    if (w == 0) begin
      return h;
    end
    return p[w-1];
  endfunction

  // Random SUM or XROT message of length 1 to MAX_LEN
  task automatic make_msg(output logic [7:0] cmd, output int len, output pay_t p);
    logic [31:0] r;
    r   = $random(seed);
    cmd = r[0] ? ZC_CMD_XROT : ZC_CMD_SUM;
    r   = $random(seed);
    len = int'(r % 32'(MAX_LEN)) + 1;
    for (int i = 0; i < MAX_LEN; i++) begin
      p[i] = '0;
      if (i < len) begin
        p[i] = $random(seed);
      end
    end
  endtask

  // Expected reply words for one message
  function automatic void zc_ref_reply(input logic [7:0] cmd, input int len,
                                       input pay_t p, output logic [31:0] hdr_w,
                                       output logic [31:0] val_w);
    logic [31:0] acc;
    logic [7:0]  st;
    acc = '0;
    st  = ZC_ST_OK;
    for (int i = 0; i < len; i++) begin
      if (cmd == ZC_CMD_SUM) begin
        acc = acc + p[i];
      end else if (cmd == ZC_CMD_XROT) begin
        acc = {acc[30:0], acc[31]} ^ p[i];
      end
    end
    case (cmd)
      ZC_CMD_STATUS: val_w = ZC_VERSION;
      ZC_CMD_SUM,
      ZC_CMD_XROT:   val_w = acc;
      default: begin
        // Unknown code swallows its payload
        st    = ZC_ST_BAD_CMD;
        val_w = '0;
      end
    endcase
    hdr_w = {cmd, st, 16'h0001};
  endfunction

  task automatic send_msg(input logic [7:0] cmd, input int len, input pay_t p);
    for (int w = 0; w <= len; w++) begin
      cmd_write(msg_word(cmd, len, p, w));
    end
  endtask

  task automatic expect_reply(input logic [7:0] cmd, input int len, input pay_t p);
    logic [31:0] hdr_w;
    logic [31:0] val_w;
    zc_ref_reply(cmd, len, p, hdr_w, val_w);
    exp_q.push_back(hdr_w);
    exp_q.push_back(val_w);
    n_exp += 2;
  endtask

  // Poll STAT until a full reply is offered
  task automatic wait_reply();
    logic [31:0] d;
    logic        err;
    zc_stat_t    stat;
    int          polls;
    polls = 0;
    apb_read(ZC_REG_STAT, d, err);
    stat = zc_stat_t'(d);
    while (stat.rpl_count != 8'd2) begin
      polls++;
      if (err || polls > POLL_MAX) begin
        fail_run("no reply showed up in STAT within the poll limit");
      end
      apb_read(ZC_REG_STAT, d, err);
      stat = zc_stat_t'(d);
    end
  endtask

  task automatic collect_reply();
    logic [31:0] d;
    logic        err;
    wait_reply();
    repeat (2) begin
      apb_read(ZC_REG_RPL, d, err);
      if (err) begin
        fail_run("an RPL read got pslverr with a reply pending");
      end
      got_q.push_back(d);
    end
  endtask

  task automatic run_msg(input logic [7:0] cmd, input int len, input pay_t p);
    send_msg(cmd, len, p);
    expect_reply(cmd, len, p);
    collect_reply();
  endtask

  // --------------------------------------------------------------------------
  // Reply compare process
  // --------------------------------------------------------------------------
  initial begin
    logic [31:0] got_w;
    logic [31:0] exp_w;
    string       name;
    forever begin
      @(posedge clk_100);
      while (got_q.size() > 0 && exp_q.size() > 0) begin
        got_w = got_q.pop_front();
        exp_w = exp_q.pop_front();
        if (n_cmp % 2 == 0) begin
          name = "rpl_hdr";
        end else begin
          name = "rpl_value";
        end
        check_val(name, got_w, exp_w);
        n_cmp++;
      end
    end
  end

  // Watchdog scaled to the message count
  initial begin
    wait (rst_main_n === 1'b1);
    repeat (WD_CYCLES) @(posedge clk_100);
    fail_run("watchdog expired before the tests finished");
  end

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin
    logic [31:0] d;
    logic        err;
    zc_stat_t    stat;
    logic [7:0]  cmd;
    int          len;
    pay_t        p;
    logic        stop;
    int          n_done;
    int          part_w;

    apb = '0;
    wait (rst_main_n === 1'b1);

    // STAT empty after reset and RPL read errors
    apb_read(ZC_REG_STAT, d, err);
    check_val("stat", d, 32'h0);
    check_val("pslverr", 32'(err), 32'h0);
    apb_read(ZC_REG_RPL, d, err);
    check_val("prdata", d, 32'h0);
    check_val("pslverr", 32'(err), 32'h1);
    // The RPL error sets the sticky bit
    apb_read(ZC_REG_STAT, d, err);
    stat = zc_stat_t'(d);
    check_val("stat.bus_err", 32'(stat.bus_err), 32'h1);

    // STATUS with no payload
    p = '{default: '0};
    run_msg(ZC_CMD_STATUS, 0, p);

    // Random SUM and XROT messages
    for (int m = 0; m < NUM_RAND; m++) begin
      make_msg(cmd, len, p);
      run_msg(cmd, len, p);
    end

    // Unknown code followed by a good message
    make_msg(cmd, len, p);
    run_msg(CMD_UNKNOWN, len, p);
    make_msg(cmd, len, p);
    run_msg(cmd, len, p);

    // Fill the core without reading until a CMD write fails
    stop   = 1'b0;
    n_done = 0;
    part_w = 0;
    for (int m = 0; m < BP_MSGS && !stop; m++) begin
      make_msg(cmd, len, p);
      bp_cmd[m] = cmd;
      bp_len[m] = len;
      bp_pay[m] = p;
      for (int w = 0; w <= len && !stop; w++) begin
        apb_read(ZC_REG_STAT, d, err);
        stat = zc_stat_t'(d);
        apb_write(ZC_REG_CMD, msg_word(cmd, len, p, w));
        if (wr_err) begin
          // Error allowed only with full already visible
          check_val("stat.cmd_full", 32'(stat.cmd_full), 32'h1);
          stop   = 1'b1;
          part_w = w;
        end
      end
      if (!stop) begin
        n_done = m + 1;
      end
    end
    if (!stop || n_done < 5) begin
      fail_run("command FIFO overflow did not occur as expected");
    end
    apb_read(ZC_REG_STAT, d, err);
    stat = zc_stat_t'(d);
    check_val("stat.bus_err", 32'(stat.bus_err), 32'h1);

    // Drain the complete messages in order
    for (int m = 0; m < n_done; m++) begin
      expect_reply(bp_cmd[m], bp_len[m], bp_pay[m]);
      collect_reply();
    end
    // Finish the cut message from the dropped word on
    for (int w = part_w; w <= bp_len[n_done]; w++) begin
      cmd_write(msg_word(bp_cmd[n_done], bp_len[n_done], bp_pay[n_done], w));
    end
    expect_reply(bp_cmd[n_done], bp_len[n_done], bp_pay[n_done]);
    collect_reply();

    // Unmapped offsets with a reply pending
    make_msg(cmd, len, p);
    send_msg(cmd, len, p);
    expect_reply(cmd, len, p);
    wait_reply();
    apb_read(8'h0c, d, err);
    check_val("pslverr", 32'(err), 32'h1);
    apb_write(8'h40, 32'hdead_beef);
    check_val("pslverr", 32'(wr_err), 32'h1);
    apb_read(ZC_REG_STAT, d, err);
    stat = zc_stat_t'(d);
    check_val("stat.rpl_count", 32'(stat.rpl_count), 32'h2);
    collect_reply();

    // Let the compare process catch up
    while (got_q.size() != 0) begin
      @(posedge clk_100);
    end
    @(posedge clk_100);
    if (n_cmp == n_exp && exp_q.size() == 0) begin
      $display("Test OK");
      $finish;
    end else begin
      fail_run("number of compared reply words does not match the expected count");
    end
  end

endmodule

//--- files.f
logic/zc_msg_pkg.sv
logic/zc_host_pkg.sv
logic/zc_fifo.sv
logic/zc_apb_regs.sv
logic/zc_decode.sv
logic/zc_execute.sv
logic/zc_result.sv
logic/zc_accel_top.sv
tests/zc_tb_clock.sv
tests/zc_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and look for the pass line
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module zc_tb -f files.f -o zc_sim

# The simulator exits nonzero on failure; the grep below decides
sim_out=$(./obj_dir/zc_sim 2>&1) || true
echo "$sim_out"

if grep -qx "Test OK" <<< "$sim_out"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
